// File: Makefile
# Verilator build and run of the L2 cache testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= l2_cache_tb
FILELIST  ?= l2_cache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/l2_cache_asserts.sv
// Handshake checks for l2_controller, attached with bind.
// Busy means from an accepted request up to its response.
`timescale 1ns/1ps

module l2_cache_asserts (
  input logic              stb,
  input logic              stb_n,
  input logic              req_valid,
  input logic              req_ready,
  input logic              rsp_valid,
  input logic              mem_req_valid,
  input logic              mem_req_ready,
  input l2_bus_pkg::addr_t mem_addr
);

  logic busy_q;  // One request outstanding.

  // Set on acceptance, cleared by the response pulse.
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      busy_q <= 1'b0;
    end
    else if (req_valid && req_ready)
    begin
      busy_q <= 1'b1;
    end
    else if (rsp_valid)
    begin
      busy_q <= 1'b0;
    end
  end

  // Memory request and its address hold until the grant.
  mem_req_hold: assert property (@(posedge stb) disable iff (!stb_n)
    (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_addr)))
  else $error("mem_req_valid or mem_addr changed before mem_req_ready");

  // Response is a single-cycle pulse.
  rsp_one_cycle: assert property (@(posedge stb) disable iff (!stb_n)
    rsp_valid |=> !rsp_valid)
  else $error("rsp_valid was high for more than one cycle");

  // No new request while one is in flight.
  ready_when_idle: assert property (@(posedge stb) disable iff (!stb_n)
    busy_q |-> !req_ready)
  else $error("req_ready was high while the controller was busy");

endmodule

bind l2_controller l2_cache_asserts u_asserts (
  .stb(stb),
  .stb_n(stb_n),
  .req_valid(req_valid),
  .req_ready(req_ready),
  .rsp_valid(rsp_valid),
  .mem_req_valid(mem_req_valid),
  .mem_req_ready(mem_req_ready),
  .mem_addr(mem_addr)
);

// File: bench/l2_cache_tb.sv
// Self-checking testbench for l2_cache_top; stops at the first error.
// Memory word at address a is a ^ 32'h5A5A0000; fills use random gaps.
// Outputs are sampled on the falling edge, inputs driven 1 ns after the rising edge.
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_cache_tb;
  import l2_cache_pkg::*;
  import l2_bus_pkg::*;

  localparam int    TIMEOUT = 200;            // Cycles allowed for any one wait.
  localparam word_t MEM_KEY = 32'h5A5A_0000;

  logic    stb;
  logic    stb_n;
  logic    req_valid;
  logic    req_ready;
  req_op_t req_op;
  addr_t   req_addr;
  word_t   req_wdata;
  logic    rsp_valid;
  word_t   rsp_rdata;
  logic    mem_req_valid;
  logic    mem_req_ready;
  addr_t   mem_addr;
  logic    mem_rd_valid;
  beat_t   mem_rd_data;
  cnt_t    hit_count;
  cnt_t    miss_count;

  // Reference cache state.
  logic  ref_valid [`L2_WAYS][`L2_SETS];
  tag_t  ref_tag   [`L2_WAYS][`L2_SETS];
  plru_t ref_tree  [`L2_SETS];                 // [2] root, [1] left, [0] right.
  word_t ref_data  [`L2_WAYS][`L2_SETS][1 << `L2_OFFSET_W];
  cnt_t  exp_hits;
  cnt_t  exp_misses;
  word_t exp_q [$];                            // Expected words, in request order.
  logic  exp_rd_q [$];                         // Set for reads.
  word_t cmp_word;
  logic  cmp_rd;

  l2_cache_top u_l2_cache_top (
    .stb(stb), .stb_n(stb_n),
    .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
    .req_addr(req_addr), .req_wdata(req_wdata),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
    .mem_addr(mem_addr), .mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data),
    .hit_count(hit_count), .miss_count(miss_count)
  );

  initial stb = 1'b0;
  always #5 stb = ~stb;  // 10 ns period.

  function automatic word_t mem_word(addr_t a);
    return a ^ MEM_KEY;
  endfunction

  function automatic addr_t make_addr(tag_t t, index_t s, offset_t o);
    return {t, s, o};
  endfunction

  // Updates the reference cache and returns the word a read would see.
  function automatic word_t model_access(req_op_t op, addr_t a, word_t wd);
    tag_t    t;
    index_t  s;
    offset_t o;
    int      w;
    t = a[`L2_ADDR_W-1 -: `L2_TAG_W];
    s = a[`L2_OFFSET_W +: `L2_INDEX_W];
    o = a[`L2_OFFSET_W-1:0];
    w = -1;
    for (int i = 0; i < `L2_WAYS; i++)
    begin
      if (ref_valid[i][s] && (ref_tag[i][s] == t))
      begin
        w = i;
      end
    end
    if (w >= 0)
    begin
      exp_hits++;
    end
    else
    begin
      exp_misses++;
      for (int i = `L2_WAYS - 1; i >= 0; i--)
      begin
        if (!ref_valid[i][s])
        begin
          w = i;  // Lowest free way wins.
        end
      end
      if (w < 0)
      begin
        if (!ref_tree[s][2])
        begin
          w = ref_tree[s][1] ? 1 : 0;
        end
        else
        begin
          w = ref_tree[s][0] ? 3 : 2;
        end
      end
      ref_valid[w][s] = 1'b1;
      ref_tag[w][s]   = t;
      for (int i = 0; i < (1 << `L2_OFFSET_W); i++)
      begin
        ref_data[w][s][i] = mem_word(make_addr(t, s, offset_t'(i)));
      end
    end
    if (op == OP_WRITE)
    begin
      ref_data[w][s][o] = wd;
    end
    case (w)
      0:       {ref_tree[s][2], ref_tree[s][1]} = 2'b11;
      1:       {ref_tree[s][2], ref_tree[s][1]} = 2'b10;
      2:       {ref_tree[s][2], ref_tree[s][0]} = 2'b01;
      default: {ref_tree[s][2], ref_tree[s][0]} = 2'b00;
    endcase
    return ref_data[w][s][o];
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic expect_hit_timing(input int lat);
    if (lat != 2)
    begin
      $display("Hit response came %0d cycles after acceptance instead of 2.", lat);
      abort_run();
    end
  endtask

  // One request, from 1 ns after a rising edge to 1 ns after the edge that ends RESP.
  task automatic do_access(input req_op_t op, input addr_t a, input word_t wd,
                           output word_t rd, output int lat);
    int n;
    n         = 0;
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = a;
    req_wdata = wd;
    @(negedge stb);
    while (!req_ready)
    begin
      n++;
      if (n > TIMEOUT)
      begin
        $display("Timed out waiting for req_ready at %0t ns.", $time);
        abort_run();
      end
      @(negedge stb);
    end
    exp_q.push_back(model_access(op, a, wd));  // Accepted on the next edge.
    exp_rd_q.push_back(op == OP_READ);
    @(posedge stb);
    #1;
    req_valid = 1'b0;
    lat = 0;
    do
    begin
      @(negedge stb);
      lat++;
      if (lat > TIMEOUT)
      begin
        $display("Timed out waiting for rsp_valid at %0t ns.", $time);
        abort_run();
      end
    end
    while (!rsp_valid);
    rd = rsp_rdata;
    @(posedge stb);
    #1;
  endtask

  // Compare every response with the reference.
  always @(negedge stb)
  begin
    if (stb_n && rsp_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("A response arrived with no request outstanding at %0t ns.", $time);
        abort_run();
      end
      else
      begin
        cmp_word = exp_q.pop_front();
        cmp_rd   = exp_rd_q.pop_front();
        if (cmp_rd)
        begin
          check_word("rsp_rdata", rsp_rdata, cmp_word);
        end
      end
    end
  end

  // Burst memory: grant after a random delay, then the beats with random gaps.
  initial
  begin
    addr_t base;
    forever
    begin
      @(posedge stb);
      #1;
      if (stb_n && mem_req_valid)
      begin
        base = mem_addr;
        repeat ($urandom_range(3))
        begin
          @(posedge stb);
          #1;
        end
        mem_req_ready = 1'b1;
        @(posedge stb);
        #1;
        mem_req_ready = 1'b0;
        for (int k = 0; k < `L2_BURST_LEN; k++)
        begin
          repeat ($urandom_range(2))
          begin
            @(posedge stb);
            #1;
          end
          mem_rd_valid = 1'b1;
          mem_rd_data  = {mem_word(base + addr_t'(2 * k + 1)), mem_word(base + addr_t'(2 * k))};
          @(posedge stb);
          #1;
          mem_rd_valid = 1'b0;
        end
      end
    end
  end

  initial
  begin
    word_t rd;
    int    lat;
    addr_t a;
    void'($urandom(91584));
    stb_n         = 1'b0;
    req_valid     = 1'b0;
    req_op        = OP_READ;
    req_addr      = '0;
    req_wdata     = '0;
    mem_req_ready = 1'b0;
    mem_rd_valid  = 1'b0;
    mem_rd_data   = '0;
    exp_hits      = '0;
    exp_misses    = '0;
    for (int s = 0; s < `L2_SETS; s++)
    begin
      ref_tree[s] = '0;
      for (int w = 0; w < `L2_WAYS; w++)
      begin
        ref_valid[w][s] = 1'b0;
      end
    end
    repeat (16) @(posedge stb);
    #1;
    stb_n = 1'b1;
    check_count("hit_count", hit_count, 16'd0);
    check_count("miss_count", miss_count, 16'd0);

    // Read miss on a fresh line.
    a = make_addr(24'h00_0012, 4'd2, 4'd7);
    do_access(OP_READ, a, '0, rd, lat);
    check_word("rsp_rdata", rd, mem_word(a));
    check_count("miss_count", miss_count, 16'd1);

    // Same line again is a two-cycle hit.
    do_access(OP_READ, a + 32'd1, '0, rd, lat);
    expect_hit_timing(lat);
    check_word("rsp_rdata", rd, mem_word(a + 32'd1));
    check_count("hit_count", hit_count, 16'd1);

    // Write hit and write miss, each read back.
    do_access(OP_WRITE, a, 32'hCAFE_0001, rd, lat);
    do_access(OP_READ, a, '0, rd, lat);
    check_word("rsp_rdata", rd, 32'hCAFE_0001);
    a = make_addr(24'h00_0034, 4'd9, 4'd12);
    do_access(OP_WRITE, a, 32'hCAFE_0002, rd, lat);
    do_access(OP_READ, a, '0, rd, lat);
    expect_hit_timing(lat);
    check_word("rsp_rdata", rd, 32'hCAFE_0002);

    // Five tags in set 5. Way 0 is the PLRU victim after ways 0..3 are touched in order.
    a = make_addr(24'h00_0100, 4'd5, 4'd3);
    do_access(OP_WRITE, a, 32'hDEAD_BEEF, rd, lat);
    for (int i = 1; i < 5; i++)
    begin
      do_access(OP_READ, make_addr(tag_t'(24'h100 + i), 4'd5, 4'd0), '0, rd, lat);
    end
    for (int i = 1; i < 4; i++)
    begin
      do_access(OP_READ, make_addr(tag_t'(24'h100 + i), 4'd5, 4'd1), '0, rd, lat);
      expect_hit_timing(lat);  // Ways 1..3 survived.
    end
    do_access(OP_READ, a, '0, rd, lat);
    check_word("rsp_rdata", rd, mem_word(a));  // Written word is gone.
    check_count("hit_count", hit_count, 16'd7);
    check_count("miss_count", miss_count, 16'd8);

    // Random mix over four sets and six tags.
    repeat (400)
    begin
      a = make_addr(tag_t'(24'h300 + $urandom_range(5)), index_t'($urandom_range(3)),
                    offset_t'($urandom_range(15)));
      if ($urandom_range(1) == 1)
      begin
        do_access(OP_WRITE, a, word_t'($urandom), rd, lat);
      end
      else
      begin
        do_access(OP_READ, a, '0, rd, lat);
      end
    end
    check_count("hit_count", hit_count, exp_hits);
    check_count("miss_count", miss_count, exp_misses);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: hw/l2_bus_pkg.sv
// Types of the L1 request bus and the memory burst bus.
`include "l2_defs.svh"

package l2_bus_pkg;

  typedef logic [`L2_ADDR_W-1:0] addr_t;  // Word address.
  typedef logic [`L2_WORD_W-1:0] word_t;  // L1 data word.
  typedef logic [`L2_BEAT_W-1:0] beat_t;  // Low word first in line order.

  // L1 request opcode.
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } req_op_t;

endpackage

// File: hw/l2_cache_pkg.sv
// Types of the cache organization and of the controller FSM.
// Widths follow the macros in l2_defs.svh.
`include "l2_defs.svh"

package l2_cache_pkg;

  // Address fields.
  typedef logic [`L2_TAG_W-1:0]    tag_t;
  typedef logic [`L2_INDEX_W-1:0]  index_t;
  typedef logic [`L2_OFFSET_W-1:0] offset_t;

  // Way number and the three tree bits of one set.
  typedef logic [$clog2(`L2_WAYS)-1:0] way_t;
  typedef logic [`L2_WAYS-2:0]         plru_t;  // [2] root, [1] left pair, [0] right pair.

  // Beat number inside a fill burst.
  typedef logic [$clog2(`L2_BURST_LEN)-1:0] beat_cnt_t;

  // Controller states.
  typedef enum logic [1:0] {
    IDLE,    // Waiting for a request.
    LOOKUP,  // Tag compare on the latched address.
    FILL,    // Memory request and burst.
    RESP     // One-cycle response.
  } ctrl_state_t;

  // Statistics count.
  typedef logic [`L2_CNT_W-1:0] cnt_t;

endpackage

// File: hw/l2_cache_top.sv
// 4-way L2 cache between an L1 requester and a burst memory.
// A hit answers in two cycles; a miss waits for a full line fill.
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_cache_top (
  input  logic                stb,
  input  logic                stb_n,
  input  logic                req_valid,
  output logic                req_ready,
  input  l2_bus_pkg::req_op_t req_op,
  input  l2_bus_pkg::addr_t   req_addr,
  input  l2_bus_pkg::word_t   req_wdata,
  output logic                rsp_valid,
  output l2_bus_pkg::word_t   rsp_rdata,
  output logic                mem_req_valid,
  input  logic                mem_req_ready,
  output l2_bus_pkg::addr_t   mem_addr,
  input  logic                mem_rd_valid,
  input  l2_bus_pkg::beat_t   mem_rd_data,
  output l2_cache_pkg::cnt_t  hit_count,
  output l2_cache_pkg::cnt_t  miss_count
);
  import l2_cache_pkg::*;
  import l2_bus_pkg::*;

  index_t    index;
  tag_t      tag;
  offset_t   offset;
  way_t      way;
  way_t      hit_way;
  way_t      free_way;
  way_t      victim_way;
  beat_cnt_t beat_idx;
  word_t     wdata;
  logic      hit;
  logic      free_found;
  logic      fill_en;
  logic      wr_en;
  logic      touch_en;
  logic      tag_fill_en;

  // Tag and valid are written with the last beat of the burst.
  assign tag_fill_en = fill_en && (beat_idx == beat_cnt_t'(`L2_BURST_LEN - 1));

  l2_controller u_ctrl (
    .stb(stb), .stb_n(stb_n),
    .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
    .req_addr(req_addr), .req_wdata(req_wdata), .rsp_valid(rsp_valid),
    .hit(hit), .hit_way(hit_way), .free_found(free_found), .free_way(free_way),
    .victim_way(victim_way),
    .index(index), .tag(tag), .offset(offset), .way(way),
    .fill_en(fill_en), .wr_en(wr_en), .wdata(wdata), .touch_en(touch_en),
    .beat_idx(beat_idx),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
    .mem_addr(mem_addr), .mem_rd_valid(mem_rd_valid),
    .hit_count(hit_count), .miss_count(miss_count)
  );

  l2_tag_store u_tags (
    .stb(stb), .stb_n(stb_n), .index(index), .tag(tag),
    .fill_en(tag_fill_en), .fill_way(way),
    .hit(hit), .hit_way(hit_way), .free_found(free_found), .free_way(free_way)
  );

  l2_plru u_plru (
    .stb(stb), .stb_n(stb_n), .index(index),
    .touch_en(touch_en), .touch_way(way), .victim_way(victim_way)
  );

  l2_data_store u_data (
    .stb(stb), .way(way), .index(index), .offset(offset), .beat_idx(beat_idx),
    .fill_en(fill_en), .fill_beat(mem_rd_data),  // Memory beats go straight in.
    .wr_en(wr_en), .wdata(wdata), .rdata(rsp_rdata)
  );

endmodule

// File: hw/l2_controller.sv
// Request FSM: one request in flight, allocate on every miss.
// After a fill the request goes through LOOKUP again and hits there;
// that second lookup is not counted. Evicted data is never written back.
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_controller (
  input  logic                    stb,
  input  logic                    stb_n,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  l2_bus_pkg::req_op_t     req_op,
  input  l2_bus_pkg::addr_t       req_addr,
  input  l2_bus_pkg::word_t       req_wdata,
  output logic                    rsp_valid,
  input  logic                    hit,
  input  l2_cache_pkg::way_t      hit_way,
  input  logic                    free_found,
  input  l2_cache_pkg::way_t      free_way,
  input  l2_cache_pkg::way_t      victim_way,
  output l2_cache_pkg::index_t    index,
  output l2_cache_pkg::tag_t      tag,
  output l2_cache_pkg::offset_t   offset,
  output l2_cache_pkg::way_t      way,
  output logic                    fill_en,
  output logic                    wr_en,
  output l2_bus_pkg::word_t       wdata,
  output logic                    touch_en,
  output l2_cache_pkg::beat_cnt_t beat_idx,
  output logic                    mem_req_valid,
  input  logic                    mem_req_ready,
  output l2_bus_pkg::addr_t       mem_addr,
  input  logic                    mem_rd_valid,
  output l2_cache_pkg::cnt_t      hit_count,
  output l2_cache_pkg::cnt_t      miss_count
);
  import l2_cache_pkg::*;
  import l2_bus_pkg::*;

  localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(`L2_BURST_LEN - 1);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  req_op_t     op_q;        // Latched request.
  addr_t       addr_q;
  word_t       wdata_q;
  way_t        fill_way_q;  // Way being refilled.
  logic        filled_q;    // Set while the request re-runs LOOKUP after its fill.
  logic        mem_req_q;
  beat_cnt_t   beat_q;
  logic        lookup_hit;

  // Address fields of the latched request.
  assign tag    = addr_q[`L2_ADDR_W-1 -: `L2_TAG_W];
  assign index  = addr_q[`L2_OFFSET_W +: `L2_INDEX_W];
  assign offset = addr_q[`L2_OFFSET_W-1:0];

  assign req_ready     = (state_q == IDLE);
  assign rsp_valid     = (state_q == RESP);
  assign mem_req_valid = mem_req_q;
  assign mem_addr      = {tag, index, {`L2_OFFSET_W{1'b0}}};  // Line aligned.

  assign lookup_hit = (state_q == LOOKUP) && hit;
  assign fill_en    = (state_q == FILL) && !mem_req_q && mem_rd_valid;  // Beats follow the grant.
  assign wr_en      = lookup_hit && (op_q == OP_WRITE);
  assign touch_en   = lookup_hit;  // Every completed access is a use.
  assign wdata      = wdata_q;
  assign beat_idx   = beat_q;
  assign way        = (state_q == FILL) ? fill_way_q : hit_way;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_valid) state_d = LOOKUP;
      LOOKUP:  state_d = hit ? RESP : FILL;
      FILL:    if (fill_en && (beat_q == LAST_BEAT)) state_d = LOOKUP;  // Tag now written.
      default: state_d = IDLE;  // RESP.
    endcase
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      state_q    <= IDLE;
      filled_q   <= 1'b0;
      mem_req_q  <= 1'b0;
      beat_q     <= '0;
      hit_count  <= '0;
      miss_count <= '0;
    end
    else
    begin
      state_q <= state_d;
      if ((state_q == LOOKUP) && !filled_q)
      begin
        if (hit)
        begin
          hit_count <= hit_count + 1'b1;
        end
        else
        begin
          miss_count <= miss_count + 1'b1;
          mem_req_q  <= 1'b1;  // Ask for the line.
        end
      end
      if (mem_req_q && mem_req_ready)
      begin
        mem_req_q <= 1'b0;
      end
      if (fill_en)
      begin
        beat_q <= beat_q + 1'b1;  // Wraps to zero after the last beat.
      end
      if (fill_en && (beat_q == LAST_BEAT))
      begin
        filled_q <= 1'b1;
      end
      else if (state_q == RESP)
      begin
        filled_q <= 1'b0;
      end
    end
  end

  // Request payload and the chosen fill way.
  always_ff @(posedge stb)
  begin
    if (req_valid && req_ready)
    begin
      op_q    <= req_op;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    if ((state_q == LOOKUP) && !hit)
    begin
      fill_way_q <= free_found ? free_way : victim_way;  // Evict only if the set is full.
    end
  end

endmodule

// File: hw/l2_data_store.sv
// Line data, split into even and odd word banks so a fill beat
// writes two words at once. Read data appears one cycle after the address.
// fill_en and wr_en must not be high together.
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_data_store (
  input  logic                    stb,
  input  l2_cache_pkg::way_t      way,
  input  l2_cache_pkg::index_t    index,
  input  l2_cache_pkg::offset_t   offset,
  input  l2_cache_pkg::beat_cnt_t beat_idx,
  input  logic                    fill_en,
  input  l2_bus_pkg::beat_t       fill_beat,
  input  logic                    wr_en,
  input  l2_bus_pkg::word_t       wdata,
  output l2_bus_pkg::word_t       rdata
);
  import l2_bus_pkg::*;

  localparam int ROW_W = $clog2(`L2_WAYS) + `L2_INDEX_W + `L2_OFFSET_W - 1;
  localparam int ROWS  = 1 << ROW_W;

  word_t            bank_lo [ROWS];  // Even offsets.
  word_t            bank_hi [ROWS];  // Odd offsets.
  logic [ROW_W-1:0] word_row;        // Row of the addressed word.
  logic [ROW_W-1:0] fill_row;        // Row of the current beat.

  assign word_row = {way, index, offset[`L2_OFFSET_W-1:1]};
  assign fill_row = {way, index, beat_idx};

  always_ff @(posedge stb)
  begin
    if (fill_en)
    begin
      bank_lo[fill_row] <= fill_beat[`L2_WORD_W-1:0];          // Word 2k.
      bank_hi[fill_row] <= fill_beat[`L2_BEAT_W-1:`L2_WORD_W]; // Word 2k+1.
    end
    else if (wr_en && !offset[0])
    begin
      bank_lo[word_row] <= wdata;
    end
    else if (wr_en)
    begin
      bank_hi[word_row] <= wdata;
    end
    rdata <= offset[0] ? bank_hi[word_row] : bank_lo[word_row];  // Old data on a write.
  end

endmodule

// File: hw/l2_defs.svh
// Geometry of the L2 cache. Word addressing throughout.
// TAG_W + INDEX_W + OFFSET_W must equal ADDR_W.
// A fill must cover one whole line: BURST_LEN * BEAT_W = 2^OFFSET_W * WORD_W.
`ifndef L2_DEFS_SVH
`define L2_DEFS_SVH

// Bus widths.
`define L2_ADDR_W    32  // Word address.
`define L2_WORD_W    32  // L1 data word.
`define L2_BEAT_W    64  // Memory beat, two words.

// Cache organization.
`define L2_WAYS      4
`define L2_SETS      16
`define L2_INDEX_W   4   // log2 of L2_SETS.
`define L2_OFFSET_W  4   // 16 words per line.
`define L2_TAG_W     24

// Fill burst and statistics.
`define L2_BURST_LEN 8   // Beats per line fill.
`define L2_CNT_W     16  // Hit and miss counters wrap silently.

`endif

// File: hw/l2_plru.sv
// Tree pseudo-LRU, three bits per set, for a 4-way cache.
// Victim is combinational from index; a touch updates on the clock.
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_plru (
  input  logic                 stb,
  input  logic                 stb_n,
  input  l2_cache_pkg::index_t index,
  input  logic                 touch_en,
  input  l2_cache_pkg::way_t   touch_way,
  output l2_cache_pkg::way_t   victim_way
);
  import l2_cache_pkg::*;

  plru_t tree_q [`L2_SETS];
  plru_t cur;   // Bits of the addressed set.
  plru_t nxt;   // Bits after a touch.

  assign cur = tree_q[index];

  // Root picks the pair, the pair bit picks the way.
  always_comb
  begin
    if (!cur[2])
    begin
      victim_way = cur[1] ? way_t'(1) : way_t'(0);
    end
    else
    begin
      victim_way = cur[0] ? way_t'(3) : way_t'(2);
    end
  end

  // Point the tree away from the touched way.
  always_comb
  begin
    nxt = cur;
    case (touch_way)
      2'd0:    nxt[2:1] = 2'b11;
      2'd1:    nxt[2:1] = 2'b10;
      2'd2:    {nxt[2], nxt[0]} = 2'b01;
      default: {nxt[2], nxt[0]} = 2'b00;  // Way 3.
    endcase
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      for (int s = 0; s < `L2_SETS; s++)
      begin
        tree_q[s] <= '0;
      end
    end
    else if (touch_en)
    begin
      tree_q[index] <= nxt;
    end
  end

endmodule

// File: hw/l2_tag_store.sv
// Tags and valid bits for every way and set.
// Lookup outputs are combinational from index and tag.
// Tags are only meaningful where the valid bit is set.
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_tag_store (
  input  logic                 stb,
  input  logic                 stb_n,
  input  l2_cache_pkg::index_t index,
  input  l2_cache_pkg::tag_t   tag,
  input  logic                 fill_en,
  input  l2_cache_pkg::way_t   fill_way,
  output logic                 hit,
  output l2_cache_pkg::way_t   hit_way,
  output logic                 free_found,
  output l2_cache_pkg::way_t   free_way
);
  import l2_cache_pkg::*;

  tag_t                tag_mem [`L2_WAYS][`L2_SETS];
  logic [`L2_SETS-1:0] valid_q [`L2_WAYS];  // One bit per set, per way.

  // Valid bits. A fill marks its way valid.
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      for (int w = 0; w < `L2_WAYS; w++)
      begin
        valid_q[w] <= '0;
      end
    end
    else if (fill_en)
    begin
      valid_q[fill_way][index] <= 1'b1;
    end
  end

  always_ff @(posedge stb)
  begin
    if (fill_en)
    begin
      tag_mem[fill_way][index] <= tag;  // New owner of the line.
    end
  end

  // Compare all ways of the set.
  // Walking down leaves the lowest free way.
  always_comb
  begin
    hit        = 1'b0;
    hit_way    = '0;
    free_found = 1'b0;
    free_way   = '0;
    for (int w = `L2_WAYS - 1; w >= 0; w--)
    begin
      if (valid_q[w][index] && (tag_mem[w][index] == tag))
      begin
        hit     = 1'b1;
        hit_way = way_t'(w);  // At most one way matches.
      end
      if (!valid_q[w][index])
      begin
        free_found = 1'b1;
        free_way   = way_t'(w);
      end
    end
  end

endmodule

// File: l2_cache.f
+incdir+hw
hw/l2_cache_pkg.sv
hw/l2_bus_pkg.sv
hw/l2_tag_store.sv
hw/l2_plru.sv
hw/l2_data_store.sv
hw/l2_controller.sv
hw/l2_cache_top.sv
bench/l2_cache_asserts.sv
bench/l2_cache_tb.sv
